/* async_fifo_fwft.sv */
// ----------------------------------------
// Dual-clock FIFO, first-word fall-through
// Gray pointers cross through flop chains,
// head word shows on data_o while not empty
// ----------------------------------------
`timescale 1ns/100ps

module async_fifo_fwft
    import link_pkg::*;
    import cdc_pkg::*;
#(
    parameter int ADDR_WIDTH = FIFO_ADDR_WIDTH
) (
    input  logic       wr_clk_i,
    input  logic       rd_clk_i,
    input  logic       rst_n,
    input  logic       push_i,
    input  logic       pop_i,
    input  link_beat_t data_i,
    output link_beat_t data_o,
    output logic       empty_o,
    output logic       full_o
);

    // Wrap bits follow the package pointer format
    localparam int PTR_WIDTH = ADDR_WIDTH + (FIFO_PTR_WIDTH - FIFO_ADDR_WIDTH);
    localparam int DEPTH     = 1 << ADDR_WIDTH;

    // Storage, no reset on payload
    link_beat_t mem [DEPTH];

    logic [PTR_WIDTH-1:0] wr_bin_q;
    logic [PTR_WIDTH-1:0] wr_bin_d;
    logic [PTR_WIDTH-1:0] wr_gray_q;
    logic [PTR_WIDTH-1:0] rd_bin_q;
    logic [PTR_WIDTH-1:0] rd_bin_d;
    logic [PTR_WIDTH-1:0] rd_gray_q;

    // Synchronizer chains, last stage is the usable copy
    logic [PTR_WIDTH-1:0] rd_gray_sync [SYNC_STAGES];
    logic [PTR_WIDTH-1:0] wr_gray_sync [SYNC_STAGES];

    logic wr_en;
    logic rd_en;

    // ----------------------------------------
    // Write side
    // ----------------------------------------
    assign wr_en    = push_i & ~full_o;
    assign wr_bin_d = wr_bin_q + PTR_WIDTH'(wr_en);

    always_ff @(posedge wr_clk_i or negedge rst_n) begin
        if (!rst_n) begin
            wr_bin_q  <= '0;
            wr_gray_q <= '0;
        end else begin
            wr_bin_q  <= wr_bin_d;
            // Binary to Gray on the next value
            wr_gray_q <= wr_bin_d ^ (wr_bin_d >> 1);
        end
    end

    always_ff @(posedge wr_clk_i) begin
        if (wr_en) begin
            mem[wr_bin_q[ADDR_WIDTH-1:0]] <= data_i;
        end
    end

    // Read pointer into write domain
    always_ff @(posedge wr_clk_i or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                rd_gray_sync[i] <= '0;
            end
        end else begin
            rd_gray_sync[0] <= rd_gray_q;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                rd_gray_sync[i] <= rd_gray_sync[i-1];
            end
        end
    end

    // Full when the top two Gray bits differ and the rest match
    assign full_o = (wr_gray_q == {~rd_gray_sync[SYNC_STAGES-1][PTR_WIDTH-1 -: 2],
                                   rd_gray_sync[SYNC_STAGES-1][PTR_WIDTH-3:0]});

    // ----------------------------------------
    // Read side
    // ----------------------------------------
    assign rd_en    = pop_i & ~empty_o;
    assign rd_bin_d = rd_bin_q + PTR_WIDTH'(rd_en);

    always_ff @(posedge rd_clk_i or negedge rst_n) begin
        if (!rst_n) begin
            rd_bin_q  <= '0;
            rd_gray_q <= '0;
        end else begin
            rd_bin_q  <= rd_bin_d;
            rd_gray_q <= rd_bin_d ^ (rd_bin_d >> 1);
        end
    end

    // Write pointer into read domain
    always_ff @(posedge rd_clk_i or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                wr_gray_sync[i] <= '0;
            end
        end else begin
            wr_gray_sync[0] <= wr_gray_q;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                wr_gray_sync[i] <= wr_gray_sync[i-1];
            end
        end
    end

    assign empty_o = (rd_gray_q == wr_gray_sync[SYNC_STAGES-1]);

    // Head word straight from memory
    assign data_o = mem[rd_bin_q[ADDR_WIDTH-1:0]];

    // Writer must respect full, reader must respect empty
    a_no_overflow: assert property (@(posedge wr_clk_i) disable iff (!rst_n)
        push_i |-> !full_o);
    a_no_underflow: assert property (@(posedge rd_clk_i) disable iff (!rst_n)
        pop_i |-> !empty_o);

endmodule

/* build.f */
link_pkg.sv
cdc_pkg.sv
async_fifo_fwft.sv
off_side_ctrl.sv
core_side_ctrl.sv
off_chip_itf.sv
tb_off_chip_itf.sv

/* cdc_pkg.sv */
// ----------------------------------------
// Clock-domain crossing package
// FIFO sizing and synchronizer depth
// ----------------------------------------
package cdc_pkg;

    // Address bits, depth of 16 words
    localparam int FIFO_ADDR_WIDTH = 4;

    // Address plus the wrap bit
    localparam int FIFO_PTR_WIDTH = 5;

    // Flops per pointer synchronizer
    localparam int SYNC_STAGES = 2;

endpackage

/* core_side_ctrl.sv */
// ----------------------------------------
// Core side controller, core clock domain
// Routes inbound beats to CCU or GIC and
// merges monitor and GIC traffic outbound
// ----------------------------------------
`timescale 1ns/100ps

module core_side_ctrl
    import link_pkg::*;
(
    input  logic       core_clk_i,
    input  logic       rst_n,
    // To the CCU
    output logic       ccu_vld_o,
    output logic       ccu_last_o,
    output port_data_t ccu_dat_o,
    input  logic       ccu_rdy_i,
    // To the GIC
    output logic       gic_vld_o,
    output logic       gic_last_o,
    output port_data_t gic_dat_o,
    input  logic       gic_rdy_i,
    // From the GIC
    input  logic       gic_in_vld_i,
    input  logic       gic_in_last_i,
    input  logic       gic_in_cmd_i,
    input  port_data_t gic_in_dat_i,
    output logic       gic_in_rdy_o,
    // From the monitor
    input  logic       mon_vld_i,
    input  logic       mon_last_i,
    input  port_data_t mon_dat_i,
    output logic       mon_rdy_o,
    // Inbound FIFO read port
    output logic       in_pop_o,
    input  link_beat_t in_beat_i,
    input  logic       in_empty_i,
    // Outbound FIFO write port
    output logic       out_push_o,
    output link_beat_t out_beat_o,
    input  logic       out_full_i
);

    link_state_e state_q;
    link_state_e state_d;

    // Monitor owns the current outbound packet
    logic mon_own_q;

    logic in_active;
    logic out_open;

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            // Inbound data first, then either outbound source
            LINK_IDLE: begin
                if (!in_empty_i) begin
                    state_d = LINK_IN2CHIP;
                end else if (gic_in_vld_i || mon_vld_i) begin
                    state_d = LINK_OUT2OFF;
                end
            end
            LINK_IN2CHIP: begin
                if (in_pop_o && in_beat_i.last) begin
                    state_d = LINK_IDLE;
                end
            end
            LINK_OUT2OFF: begin
                if (out_push_o && out_beat_o.last) begin
                    state_d = LINK_IDLE;
                end
            end
            default: state_d = LINK_IDLE;
        endcase
    end

    always_ff @(posedge core_clk_i or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= LINK_IDLE;
            mon_own_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Owner sampled in idle, monitor wins a tie
            if (state_q == LINK_IDLE) begin
                mon_own_q <= mon_vld_i;
            end
        end
    end

    // ----------------------------------------
    // Inbound, FIFO head to CCU or GIC
    // ----------------------------------------
    assign in_active = (state_q == LINK_IN2CHIP) & ~in_empty_i;

    // Instruction beats to CCU, plain data to GIC
    assign ccu_vld_o  = in_active & in_beat_i.cmd;
    assign ccu_last_o = ccu_vld_o & in_beat_i.last;
    assign ccu_dat_o  = ccu_vld_o ? in_beat_i.dat : '0;

    assign gic_vld_o  = in_active & ~in_beat_i.cmd;
    assign gic_last_o = gic_vld_o & in_beat_i.last;
    assign gic_dat_o  = gic_vld_o ? in_beat_i.dat : '0;

    // Pop once the chosen side takes the beat
    assign in_pop_o = (ccu_vld_o & ccu_rdy_i) | (gic_vld_o & gic_rdy_i);

    // ----------------------------------------
    // Outbound, source to FIFO
    // ----------------------------------------
    assign out_open     = (state_q == LINK_OUT2OFF) & ~out_full_i;
    // Only the owning source sees ready, so the other one holds
    assign mon_rdy_o    = out_open & mon_own_q;
    assign gic_in_rdy_o = out_open & ~mon_own_q;

    assign out_push_o = (mon_vld_i & mon_rdy_o) | (gic_in_vld_i & gic_in_rdy_o);

    // Monitor beats never carry a command
    always_comb begin
        if (mon_own_q) begin
            out_beat_o.dat  = mon_dat_i;
            out_beat_o.cmd  = 1'b0;
            out_beat_o.last = mon_last_i;
        end else begin
            out_beat_o.dat  = gic_in_dat_i;
            out_beat_o.cmd  = gic_in_cmd_i;
            out_beat_o.last = gic_in_last_i;
        end
    end

    a_dest_onehot: assert property (@(posedge core_clk_i) disable iff (!rst_n)
        !(ccu_vld_o && gic_vld_o));
    // Head stays put while the destination stalls
    a_head_hold: assert property (@(posedge core_clk_i) disable iff (!rst_n)
        (in_active && !in_pop_o) |=> (in_active && $stable(in_beat_i)));

endmodule

/* link_pkg.sv */
// ----------------------------------------
// Link package
// Beat format and link FSM states shared
// by the off-chip and core-side domains
// ----------------------------------------
package link_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    // Data bits carried per beat
    localparam int PORT_WIDTH = 32;

    // One beat's data word
    typedef logic [PORT_WIDTH-1:0] port_data_t;

    // ----------------------------------------
    // FIFO word
    // ----------------------------------------

    // Word stored in both crossing FIFOs
    // cmd is the instruction flag inbound and the command flag outbound
    typedef struct packed {
        port_data_t dat;
        logic       cmd;
        logic       last;
    } link_beat_t;

    // ----------------------------------------
    // Link FSM
    // ----------------------------------------

    // Same three states in both domains
    typedef enum logic [1:0] {
        LINK_IDLE    = 2'd0,
        // Off-chip to core transfer
        LINK_IN2CHIP = 2'd1,
        // Core to off-chip transfer
        LINK_OUT2OFF = 2'd2
    } link_state_e;

endpackage

/* off_chip_itf.sv */
// ----------------------------------------
// Off-chip link interface, top level
// Two domain controllers joined by an
// inbound and an outbound async FIFO
// ----------------------------------------
`timescale 1ns/100ps

module off_chip_itf
    import link_pkg::*;
    import cdc_pkg::*;
(
    input  logic       OffClk,
    input  logic       core_clk_i,
    input  logic       rst_n,
    // Inbound off-chip bus
    input  logic       off_vld_i,
    input  logic       off_last_i,
    input  logic       off_isa_i,
    input  port_data_t off_dat_i,
    output logic       off_rdy_o,
    // Outbound off-chip bus
    output logic       out_vld_o,
    output logic       out_last_o,
    output logic       out_cmd_o,
    output port_data_t out_dat_o,
    input  logic       out_rdy_i,
    // To the CCU
    output logic       ccu_vld_o,
    output logic       ccu_last_o,
    output port_data_t ccu_dat_o,
    input  logic       ccu_rdy_i,
    // To the GIC
    output logic       gic_vld_o,
    output logic       gic_last_o,
    output port_data_t gic_dat_o,
    input  logic       gic_rdy_i,
    // From the GIC
    input  logic       gic_in_vld_i,
    input  logic       gic_in_last_i,
    input  logic       gic_in_cmd_i,
    input  port_data_t gic_in_dat_i,
    output logic       gic_in_rdy_o,
    // From the monitor
    input  logic       mon_vld_i,
    input  logic       mon_last_i,
    input  port_data_t mon_dat_i,
    output logic       mon_rdy_o
);

    // Inbound FIFO, OffClk write, core read
    logic       in_push;
    logic       in_pop;
    link_beat_t in_beat_w;
    link_beat_t in_beat_r;
    logic       in_empty;
    logic       in_full;

    // Outbound FIFO, core write, OffClk read
    logic       out_push;
    logic       out_pop;
    link_beat_t out_beat_w;
    link_beat_t out_beat_r;
    logic       out_empty;
    logic       out_full;

    // ----------------------------------------
    // Domain controllers
    // ----------------------------------------
    off_side_ctrl u_off_side_ctrl (
        .OffClk      (OffClk),
        .rst_n       (rst_n),
        .off_vld_i   (off_vld_i),
        .off_last_i  (off_last_i),
        .off_isa_i   (off_isa_i),
        .off_dat_i   (off_dat_i),
        .off_rdy_o   (off_rdy_o),
        .out_vld_o   (out_vld_o),
        .out_last_o  (out_last_o),
        .out_cmd_o   (out_cmd_o),
        .out_dat_o   (out_dat_o),
        .out_rdy_i   (out_rdy_i),
        .in_push_o   (in_push),
        .in_beat_o   (in_beat_w),
        .in_full_i   (in_full),
        .out_pop_o   (out_pop),
        .out_beat_i  (out_beat_r),
        .out_empty_i (out_empty)
    );

    core_side_ctrl u_core_side_ctrl (
        .core_clk_i    (core_clk_i),
        .rst_n         (rst_n),
        .ccu_vld_o     (ccu_vld_o),
        .ccu_last_o    (ccu_last_o),
        .ccu_dat_o     (ccu_dat_o),
        .ccu_rdy_i     (ccu_rdy_i),
        .gic_vld_o     (gic_vld_o),
        .gic_last_o    (gic_last_o),
        .gic_dat_o     (gic_dat_o),
        .gic_rdy_i     (gic_rdy_i),
        .gic_in_vld_i  (gic_in_vld_i),
        .gic_in_last_i (gic_in_last_i),
        .gic_in_cmd_i  (gic_in_cmd_i),
        .gic_in_dat_i  (gic_in_dat_i),
        .gic_in_rdy_o  (gic_in_rdy_o),
        .mon_vld_i     (mon_vld_i),
        .mon_last_i    (mon_last_i),
        .mon_dat_i     (mon_dat_i),
        .mon_rdy_o     (mon_rdy_o),
        .in_pop_o      (in_pop),
        .in_beat_i     (in_beat_r),
        .in_empty_i    (in_empty),
        .out_push_o    (out_push),
        .out_beat_o    (out_beat_w),
        .out_full_i    (out_full)
    );

    // ----------------------------------------
    // Crossing FIFOs
    // ----------------------------------------
    async_fifo_fwft #(
        .ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) u_fifo_in2chip (
        .wr_clk_i (OffClk),
        .rd_clk_i (core_clk_i),
        .rst_n    (rst_n),
        .push_i   (in_push),
        .pop_i    (in_pop),
        .data_i   (in_beat_w),
        .data_o   (in_beat_r),
        .empty_o  (in_empty),
        .full_o   (in_full)
    );

    async_fifo_fwft #(
        .ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) u_fifo_out2off (
        .wr_clk_i (core_clk_i),
        .rd_clk_i (OffClk),
        .rst_n    (rst_n),
        .push_i   (out_push),
        .pop_i    (out_pop),
        .data_i   (out_beat_w),
        .data_o   (out_beat_r),
        .empty_o  (out_empty),
        .full_o   (out_full)
    );

endmodule

/* off_side_ctrl.sv */
// ----------------------------------------
// Off-chip side controller, OffClk domain
// Pushes inbound bus beats into the FIFO
// and drains the outbound FIFO to the bus
// ----------------------------------------
`timescale 1ns/100ps

module off_side_ctrl
    import link_pkg::*;
(
    input  logic       OffClk,
    input  logic       rst_n,
    // Inbound off-chip bus
    input  logic       off_vld_i,
    input  logic       off_last_i,
    input  logic       off_isa_i,
    input  port_data_t off_dat_i,
    output logic       off_rdy_o,
    // Outbound off-chip bus
    output logic       out_vld_o,
    output logic       out_last_o,
    output logic       out_cmd_o,
    output port_data_t out_dat_o,
    input  logic       out_rdy_i,
    // Inbound FIFO write port
    output logic       in_push_o,
    output link_beat_t in_beat_o,
    input  logic       in_full_i,
    // Outbound FIFO read port
    output logic       out_pop_o,
    input  link_beat_t out_beat_i,
    input  logic       out_empty_i
);

    link_state_e state_q;
    link_state_e state_d;
    link_beat_t  out_view;

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            // Off-chip request wins over pending outbound data
            LINK_IDLE: begin
                if (off_vld_i) begin
                    state_d = LINK_IN2CHIP;
                end else if (!out_empty_i) begin
                    state_d = LINK_OUT2OFF;
                end
            end
            LINK_IN2CHIP: begin
                if (in_push_o && off_last_i) begin
                    state_d = LINK_IDLE;
                end
            end
            LINK_OUT2OFF: begin
                if (out_pop_o && out_beat_i.last) begin
                    state_d = LINK_IDLE;
                end
            end
            default: state_d = LINK_IDLE;
        endcase
    end

    always_ff @(posedge OffClk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= LINK_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ----------------------------------------
    // Inbound, bus to FIFO
    // ----------------------------------------
    // Ready only while there is room
    assign off_rdy_o = (state_q == LINK_IN2CHIP) & ~in_full_i;
    assign in_push_o = off_vld_i & off_rdy_o;

    // Instruction flag rides in the cmd bit
    always_comb begin
        in_beat_o.dat  = off_dat_i;
        in_beat_o.cmd  = off_isa_i;
        in_beat_o.last = off_last_i;
    end

    // ----------------------------------------
    // Outbound, FIFO to bus
    // ----------------------------------------
    assign out_vld_o = (state_q == LINK_OUT2OFF) & ~out_empty_i;
    // Bus quiet outside outbound
    assign out_view  = out_vld_o ? out_beat_i : '0;

    assign out_dat_o  = out_view.dat;
    assign out_cmd_o  = out_view.cmd;
    assign out_last_o = out_view.last;
    assign out_pop_o  = out_vld_o & out_rdy_i;

    a_out_vld_state: assert property (@(posedge OffClk) disable iff (!rst_n)
        out_vld_o |-> (state_q == LINK_OUT2OFF));
    a_no_push_full: assert property (@(posedge OffClk) disable iff (!rst_n)
        in_push_o |-> !in_full_i);

endmodule

/* tb_off_chip_itf.sv */
// ----------------------------------------
// Off-chip link interface testbench
// Random packets in both directions over
// two unrelated clocks with queue scoreboards
// ----------------------------------------
`timescale 1ns/100ps

module tb_off_chip_itf
    import link_pkg::*;
();

    localparam int NUM_PKT    = 8;
    localparam int MAX_LEN    = 8;
    // Six phases of NUM_PKT plus the two-packet tie case
    localparam int TOTAL_PKT  = 6 * NUM_PKT + 2;
    localparam int TIMEOUT_NS = TOTAL_PKT * MAX_LEN * 40;

    logic       OffClk;
    logic       core_clk_i;
    logic       rst_n;
    logic       off_vld_i;
    logic       off_last_i;
    logic       off_isa_i;
    port_data_t off_dat_i;
    logic       off_rdy_o;
    logic       out_vld_o;
    logic       out_last_o;
    logic       out_cmd_o;
    port_data_t out_dat_o;
    logic       out_rdy_i;
    logic       ccu_vld_o;
    logic       ccu_last_o;
    port_data_t ccu_dat_o;
    logic       ccu_rdy_i;
    logic       gic_vld_o;
    logic       gic_last_o;
    port_data_t gic_dat_o;
    logic       gic_rdy_i;
    logic       gic_in_vld_i;
    logic       gic_in_last_i;
    logic       gic_in_cmd_i;
    port_data_t gic_in_dat_i;
    logic       gic_in_rdy_o;
    logic       mon_vld_i;
    logic       mon_last_i;
    port_data_t mon_dat_i;
    logic       mon_rdy_o;

    int         seed;
    int         error_count;
    // Long ready stalls so both FIFOs fill
    logic       stall_mode;
    // Set from first valid beat until the last one is taken
    logic       in_pkt_open;
    // Next outbound acceptance must come from the monitor
    logic       tie_pending;
    // Expected beats in acceptance order
    link_beat_t in_q[$];
    link_beat_t out_q[$];

    off_chip_itf off_chip_itf_inst (.*);

    // ----------------------------------------
    // Clocks at 4 ns and 6 ns
    // ----------------------------------------
    initial begin : off_clk_gen
        OffClk = 1'b0;
        forever begin
            #2 OffClk = ~OffClk;
        end
    end

    initial begin : core_clk_gen
        core_clk_i = 1'b0;
        forever begin
            #3 core_clk_i = ~core_clk_i;
        end
    end

    // ----------------------------------------
    // Failure reporting
    // ----------------------------------------
    task automatic value_mismatch(input string sig, input logic [63:0] expected,
                                  input logic [63:0] actual);
        error_count++;
        $display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h", $time, sig, expected, actual);
        $display("Done: errors found");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic plain_failure(input string what);
        error_count++;
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Done: errors found");
        $fatal(1, "Stopping at first error");
    endtask

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns without finishing its packets", TIMEOUT_NS);
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

    // ----------------------------------------
    // Random helpers and ready patterns
    // ----------------------------------------
    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Cycles to hold a ready level
    function automatic int stretch_len(input logic level);
        if (stall_mode) begin
            return level ? rand_range(3, 10) : rand_range(10, 40);
        end
        return level ? rand_range(1, 6) : rand_range(1, 2);
    endfunction

    initial begin : off_ready_gen
        int left;
        left = 0;
        forever begin
            @(posedge OffClk);
            #0.5;
            if (left == 0) begin
                out_rdy_i = ~out_rdy_i;
                left      = stretch_len(out_rdy_i);
            end else begin
                left--;
            end
        end
    end

    initial begin : core_ready_gen
        int ccu_left;
        int gic_left;
        ccu_left = 0;
        gic_left = 0;
        forever begin
            @(posedge core_clk_i);
            #0.5;
            if (ccu_left == 0) begin
                ccu_rdy_i = ~ccu_rdy_i;
                ccu_left  = stretch_len(ccu_rdy_i);
            end else begin
                ccu_left--;
            end
            if (gic_left == 0) begin
                gic_rdy_i = ~gic_rdy_i;
                gic_left  = stretch_len(gic_rdy_i);
            end else begin
                gic_left--;
            end
        end
    end

    // ----------------------------------------
    // Packet senders hold each beat until taken
    // ----------------------------------------
    task automatic send_off_pkt(input logic isa, input int len);
        @(posedge OffClk);
        #0.5;
        in_pkt_open = 1'b1;
        for (int i = 0; i < len; i++) begin
            off_vld_i  = 1'b1;
            off_isa_i  = isa;
            off_last_i = (i == len - 1);
            off_dat_i  = $random(seed);
            do begin
                @(posedge OffClk);
            end while (!off_rdy_o);
            #0.5;
        end
        off_vld_i   = 1'b0;
        off_last_i  = 1'b0;
        in_pkt_open = 1'b0;
    endtask

    task automatic send_gic_pkt(input int len);
        @(posedge core_clk_i);
        #0.5;
        for (int i = 0; i < len; i++) begin
            gic_in_vld_i  = 1'b1;
            gic_in_cmd_i  = 1'($random(seed));
            gic_in_last_i = (i == len - 1);
            gic_in_dat_i  = $random(seed);
            do begin
                @(posedge core_clk_i);
            end while (!gic_in_rdy_o);
            #0.5;
        end
        gic_in_vld_i  = 1'b0;
        gic_in_last_i = 1'b0;
    endtask

    task automatic send_mon_pkt(input int len);
        @(posedge core_clk_i);
        #0.5;
        for (int i = 0; i < len; i++) begin
            mon_vld_i  = 1'b1;
            mon_last_i = (i == len - 1);
            mon_dat_i  = $random(seed);
            do begin
                @(posedge core_clk_i);
            end while (!mon_rdy_o);
            #0.5;
        end
        mon_vld_i  = 1'b0;
        mon_last_i = 1'b0;
    endtask

    task automatic drain_queues();
        while (in_q.size() != 0 || out_q.size() != 0) begin
            @(posedge OffClk);
        end
    endtask

    task automatic check_quiet();
        assert (off_rdy_o == 1'b0) else value_mismatch("off_rdy_o", 0, off_rdy_o);
        assert (out_vld_o == 1'b0) else value_mismatch("out_vld_o", 0, out_vld_o);
        assert (ccu_vld_o == 1'b0) else value_mismatch("ccu_vld_o", 0, ccu_vld_o);
        assert (gic_vld_o == 1'b0) else value_mismatch("gic_vld_o", 0, gic_vld_o);
        assert (gic_in_rdy_o == 1'b0) else value_mismatch("gic_in_rdy_o", 0, gic_in_rdy_o);
        assert (mon_rdy_o == 1'b0) else value_mismatch("mon_rdy_o", 0, mon_rdy_o);
    endtask

    // ----------------------------------------
    // Scoreboards
    // ----------------------------------------
    // Inbound beats queued on acceptance and outbound head compared
    always @(posedge OffClk) begin : off_side_check
        link_beat_t beat;
        if (rst_n) begin
            if (off_vld_i && off_rdy_o) begin
                beat.dat  = off_dat_i;
                beat.cmd  = off_isa_i;
                beat.last = off_last_i;
                in_q.push_back(beat);
            end
            if (out_vld_o) begin
                assert (out_q.size() != 0)
                    else plain_failure("outbound beat shown with nothing sent");
                beat = out_q[0];
                assert (out_dat_o == beat.dat)
                    else value_mismatch("out_dat_o", beat.dat, out_dat_o);
                assert (out_cmd_o == beat.cmd) else value_mismatch("out_cmd_o", beat.cmd, out_cmd_o);
                assert (out_last_o == beat.last)
                    else value_mismatch("out_last_o", beat.last, out_last_o);
                if (out_rdy_i) begin
                    void'(out_q.pop_front());
                end
            end
        end
    end

    always @(posedge core_clk_i) begin : core_side_check
        link_beat_t beat;
        logic       mon_acc;
        logic       gic_acc;
        if (rst_n) begin
            mon_acc = mon_vld_i && mon_rdy_o;
            gic_acc = gic_in_vld_i && gic_in_rdy_o;
            assert (!(mon_acc && gic_acc))
                else plain_failure("GIC and monitor beats accepted on the same edge");
            // Tie in idle goes to the monitor
            if (tie_pending && (mon_acc || gic_acc)) begin
                assert (mon_acc) else value_mismatch("mon_rdy_o", 1, mon_rdy_o);
                tie_pending = 1'b0;
            end
            // Monitor beats leave with command flag 0
            if (mon_acc) begin
                beat.dat  = mon_dat_i;
                beat.cmd  = 1'b0;
                beat.last = mon_last_i;
                out_q.push_back(beat);
            end
            if (gic_acc) begin
                beat.dat  = gic_in_dat_i;
                beat.cmd  = gic_in_cmd_i;
                beat.last = gic_in_last_i;
                out_q.push_back(beat);
            end
            // Instruction beats belong at the CCU only
            if (ccu_vld_o) begin
                assert (in_q.size() != 0) else plain_failure("CCU beat with no inbound beat sent");
                beat = in_q[0];
                assert (beat.cmd) else value_mismatch("ccu_vld_o", 0, 1);
                assert (ccu_dat_o == beat.dat)
                    else value_mismatch("ccu_dat_o", beat.dat, ccu_dat_o);
                assert (ccu_last_o == beat.last)
                    else value_mismatch("ccu_last_o", beat.last, ccu_last_o);
                if (ccu_rdy_i) begin
                    void'(in_q.pop_front());
                end
            end
            if (gic_vld_o) begin
                assert (in_q.size() != 0) else plain_failure("GIC beat with no inbound beat sent");
                beat = in_q[0];
                assert (!beat.cmd) else value_mismatch("gic_vld_o", 0, 1);
                assert (gic_dat_o == beat.dat)
                    else value_mismatch("gic_dat_o", beat.dat, gic_dat_o);
                assert (gic_last_o == beat.last)
                    else value_mismatch("gic_last_o", beat.last, gic_last_o);
                if (gic_rdy_i) begin
                    void'(in_q.pop_front());
                end
            end
        end
    end

    // Ready only inside an inbound packet and never while sending out
    a_rdy_in_pkt: assert property (@(posedge OffClk) disable iff (!rst_n)
        !in_pkt_open |-> !off_rdy_o)
        else value_mismatch("off_rdy_o", 0, 1);
    a_one_direction: assert property (@(posedge OffClk) disable iff (!rst_n)
        off_rdy_o |-> !out_vld_o)
        else value_mismatch("out_vld_o", 0, 1);

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin : main_seq
        seed          = 53774;
        error_count   = 0;
        stall_mode    = 1'b0;
        in_pkt_open   = 1'b0;
        tie_pending   = 1'b0;
        rst_n         = 1'b0;
        off_vld_i     = 1'b0;
        off_last_i    = 1'b0;
        off_isa_i     = 1'b0;
        off_dat_i     = '0;
        out_rdy_i     = 1'b0;
        ccu_rdy_i     = 1'b0;
        gic_rdy_i     = 1'b0;
        gic_in_vld_i  = 1'b0;
        gic_in_last_i = 1'b0;
        gic_in_cmd_i  = 1'b0;
        gic_in_dat_i  = '0;
        mon_vld_i     = 1'b0;
        mon_last_i    = 1'b0;
        mon_dat_i     = '0;

        // Reset for 3 OffClk cycles with outputs quiet during and after
        repeat (3) begin
            @(posedge OffClk);
            check_quiet();
        end
        #0.5;
        rst_n = 1'b1;
        repeat (2) begin
            @(posedge OffClk);
            check_quiet();
        end

        // Inbound plain data and then instructions
        for (int p = 0; p < NUM_PKT; p++) begin
            send_off_pkt(1'b0, rand_range(1, MAX_LEN));
        end
        drain_queues();
        for (int p = 0; p < NUM_PKT; p++) begin
            send_off_pkt(1'b1, rand_range(1, MAX_LEN));
        end
        drain_queues();

        // Outbound from each source alone
        for (int p = 0; p < NUM_PKT; p++) begin
            send_gic_pkt(rand_range(1, MAX_LEN));
        end
        drain_queues();
        for (int p = 0; p < NUM_PKT; p++) begin
            send_mon_pkt(rand_range(1, MAX_LEN));
        end
        drain_queues();

        // Both sources valid on the same idle edge
        tie_pending = 1'b1;
        fork
            send_mon_pkt(rand_range(1, MAX_LEN));
            send_gic_pkt(rand_range(1, MAX_LEN));
        join
        drain_queues();

        // Long ready stalls fill both FIFOs
        // Both directions run at once so the off side must pick one
        stall_mode = 1'b1;
        fork
            begin
                for (int p = 0; p < NUM_PKT; p++) begin
                    send_off_pkt(1'($random(seed)), rand_range(1, MAX_LEN));
                end
            end
            begin
                for (int p = 0; p < NUM_PKT; p++) begin
                    if (p % 2 == 0) begin
                        send_gic_pkt(rand_range(1, MAX_LEN));
                    end else begin
                        send_mon_pkt(rand_range(1, MAX_LEN));
                    end
                end
            end
        join
        drain_queues();

        repeat (4) @(posedge OffClk);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
